// File: project.f
+incdir+source
source/bus_pkg.sv
source/fetch_pkg.sv
source/pc_sequencer.sv
source/icache.sv
source/jal_predecoder.sv
source/fetch_top.sv
testbench/tb_clock.sv
testbench/fetch_props.sv
testbench/fetch_tb.sv

// File: Makefile
SIM = obj_dir/fetch_sim
LOG = sim.log

.PHONY: compile run clean

compile:
	verilator --binary --timing --assert -f project.f --top-module fetch_tb \
		-Mdir obj_dir -o fetch_sim

run: compile
	./$(SIM) | tee $(LOG)
	grep -q "^No errors$$" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

// File: testbench/fetch_tb.sv
`include "fetch_defines.svh"

module fetch_tb;

  timeunit 1ns;
  timeprecision 1ps;

  import bus_pkg::*;

  localparam int lines       = 1 << `INDEX_WIDTH;
  localparam int line_shift  = `INDEX_WIDTH + `OFFSET_WIDTH;
  localparam int cycle_limit = 4000;

  logic  clock;
  logic  por_reset;
  logic  test_reset;
  logic  run;
  logic  bus_ar_ready;
  logic  bus_r_valid;
  word_t bus_r_data;
  logic  bus_ar_valid;
  addr_t bus_ar_addr;
  logic  bus_r_ready;
  logic  instr_valid;
  addr_t instr_pc;
  word_t instr_data;

  // Memory image, 1 KB, and the JAL targets placed in it
  word_t mem [0:255];
  addr_t jal_target [addr_t];

  // Responder state
  integer seed = 32'h767e;
  logic   delays_on;
  logic   pending;
  int     wait_cnt;
  addr_t  pending_addr;

  // Scoreboard
  int    errors;
  int    ar_count;
  int    ar_since;
  int    delivered;
  int    cycles;
  addr_t last_ar_addr;
  addr_t exp_pc;
  logic  held_prev;
  addr_t held_addr;
  logic  model_valid [0:lines-1];
  addr_t model_tag [0:lines-1];
  addr_t stream_pc[$];
  word_t stream_data[$];
  addr_t ref_pc[$];
  word_t ref_data[$];

  tb_clock u_clock (
    .clock (clock),
    .reset (por_reset)
  );

  fetch_top dut (
    .clock        (clock),
    .reset        (por_reset || test_reset),
    .run          (run),
    .bus_ar_ready (bus_ar_ready),
    .bus_r_valid  (bus_r_valid),
    .bus_r_data   (bus_r_data),
    .bus_ar_valid (bus_ar_valid),
    .bus_ar_addr  (bus_ar_addr),
    .bus_r_ready  (bus_r_ready),
    .instr_valid  (instr_valid),
    .instr_pc     (instr_pc),
    .instr_data   (instr_data)
  );

  // ------------------------------------------------------------
  // Program image
  // ------------------------------------------------------------

  // J-type encoding, rd = x1
  function automatic word_t encode_jal(input addr_t from, input addr_t to);
    addr_t off;
    off = to - from;
    return {off[20], off[10:1], off[11], off[19:12], 5'd1, 7'b110_1111};
  endfunction

  // ALU-type filler, never a JAL, unique per word address
  task automatic fill_memory();
    addr_t a;
    jal_target.delete();
    for (int i = 0; i < 256; i++) begin
      a = addr_t'(i) << 2;
      mem[i] = {a[26:2], 7'b001_0011};
    end
  endtask

  task automatic place_jal(input addr_t from, input addr_t to);
    mem[from[9:2]] = encode_jal(from, to);
    jal_target[from] = to;
  endtask

  // Straight block of 8 words, then JAL back to the start
  task automatic load_loop_program();
    fill_memory();
    place_jal(32'h20, 32'h0);
  endtask

  task automatic report_error(input string msg);
    errors++;
    $display("error at %0t: %s", $time, msg);
  endtask

  // ------------------------------------------------------------
  // Memory model on the read bus
  // ------------------------------------------------------------

  initial begin
    logic  ar_acc;
    logic  r_acc;
    word_t rnd;
    pending = 1'b0;
    wait_cnt = 0;
    forever begin
      @(posedge clock);
      ar_acc = bus_ar_valid && bus_ar_ready;
      r_acc  = bus_r_valid && bus_r_ready;
      if (ar_acc) begin
        pending_addr = bus_ar_addr;
      end
      #1;
      if (r_acc) begin
        bus_r_valid = 1'b0;
      end
      if (ar_acc) begin
        pending = 1'b1;
        rnd = $random(seed);
        wait_cnt = delays_on ? int'(rnd[1:0]) : 0;
      end
      // Single beat once the delay runs out
      if (pending && !bus_r_valid) begin
        if (wait_cnt == 0) begin
          bus_r_valid = 1'b1;
          bus_r_data  = mem[pending_addr[9:2]];
          pending     = 1'b0;
        end else begin
          wait_cnt--;
        end
      end
      rnd = $random(seed);
      bus_ar_ready = delays_on ? rnd[0] : 1'b1;
    end
  end

  // ------------------------------------------------------------
  // Monitor and reference model
  // ------------------------------------------------------------

  task automatic check_delivery();
    int    idx;
    addr_t tag;
    logic  miss;
    idx  = int'(exp_pc[line_shift-1:`OFFSET_WIDTH]);
    tag  = exp_pc >> line_shift;
    miss = !(model_valid[idx] && model_tag[idx] == tag);
    if (instr_pc !== exp_pc) begin
      report_error($sformatf("pc %h, expected %h", instr_pc, exp_pc));
    end
    if (instr_data !== mem[exp_pc[9:2]]) begin
      report_error($sformatf("data %h at %h, expected %h", instr_data, exp_pc,
        mem[exp_pc[9:2]]));
    end
    // Exactly one request per miss, none per hit
    if (ar_since != (miss ? 1 : 0)) begin
      report_error($sformatf("%0d requests before pc %h, expected %0d", ar_since,
        exp_pc, miss ? 1 : 0));
    end
    if (miss && last_ar_addr !== exp_pc) begin
      report_error($sformatf("request address %h, expected %h", last_ar_addr, exp_pc));
    end
    model_valid[idx] = 1'b1;
    model_tag[idx]   = tag;
    ar_since = 0;
    stream_pc.push_back(instr_pc);
    stream_data.push_back(instr_data);
    delivered++;
    if (jal_target.exists(exp_pc)) begin
      exp_pc = jal_target[exp_pc];
    end else begin
      exp_pc = exp_pc + 32'd4;
    end
  endtask

  always @(posedge clock) begin
    if (held_prev && (!bus_ar_valid || bus_ar_addr !== held_addr)) begin
      report_error($sformatf("held request %h dropped or changed", held_addr));
    end
    held_prev = bus_ar_valid && !bus_ar_ready;
    held_addr = bus_ar_addr;
    if (bus_ar_valid && bus_ar_ready) begin
      ar_count++;
      ar_since++;
      last_ar_addr = bus_ar_addr;
    end
    if (instr_valid) begin
      check_delivery();
    end
  end

  // Limit covers all tests with the slowest bus timing
  always @(posedge clock) begin
    cycles++;
    if (cycles >= cycle_limit) begin
      $display("Timeout: the run did not finish within %0d cycles", cycle_limit);
      $display("Errors found");
      $finish;
    end
  end

  // ------------------------------------------------------------
  // Sequencing helpers
  // ------------------------------------------------------------

  task automatic reset_model();
    for (int i = 0; i < lines; i++) begin
      model_valid[i] = 1'b0;
    end
    exp_pc   = `RESET_PC;
    ar_since = 0;
    stream_pc.delete();
    stream_data.delete();
  endtask

  // Quiesce the bus, then a 10-cycle reset
  task automatic restart();
    run = 1'b0;
    do begin
      @(posedge clock);
      #1;
    end while (pending || bus_r_valid || bus_ar_valid);
    test_reset = 1'b1;
    repeat (10) @(posedge clock);
    #1 test_reset = 1'b0;
    reset_model();
  endtask

  task automatic run_for(input int n);
    int target;
    target = delivered + n;
    run = 1'b1;
    do begin
      @(posedge clock);
      #1;
    end while (delivered < target);
    run = 1'b0;
  endtask

  // ------------------------------------------------------------
  // Tests
  // ------------------------------------------------------------

  // Fetch is requested through reset, so only reset keeps the port and bus quiet
  task automatic check_reset_state();
    @(posedge clock);
    #1 run = 1'b1;
    do begin
      @(posedge clock);
      if (instr_valid || bus_ar_valid) begin
        report_error("instr_valid or bus_ar_valid high in or just after reset");
      end
    end while (por_reset);
    // R channel ready straight out of reset
    if (bus_r_ready !== 1'b1) begin
      report_error("bus_r_ready low after reset");
    end
    #1;
  endtask

  task automatic test_cold_misses();
    int base;
    base = ar_count;
    run_for(9);
    if (ar_count - base != 9) begin
      report_error($sformatf("cold pass made %0d requests, expected 9", ar_count - base));
    end
    for (int i = 0; i < 9; i++) begin
      if (stream_pc[i] !== `RESET_PC + addr_t'(4 * i)) begin
        report_error($sformatf("cold pass pc %h at step %0d", stream_pc[i], i));
      end
    end
  endtask

  task automatic test_revisit_hits();
    int base;
    base = ar_count;
    run_for(9);
    if (ar_count != base) begin
      report_error($sformatf("second pass made %0d requests", ar_count - base));
    end
    if (stream_pc[9] !== 32'h0) begin
      report_error($sformatf("pc after JAL %h, expected 0", stream_pc[9]));
    end
    for (int i = 0; i < 9; i++) begin
      if (stream_pc[9+i] !== stream_pc[i] || stream_data[9+i] !== stream_data[i]) begin
        report_error($sformatf("second pass differs at step %0d", i));
      end
    end
    ref_pc   = stream_pc;
    ref_data = stream_data;
  endtask

  // 0x100 and 0x140 share line 0, every visit evicts the other
  task automatic test_conflict();
    int base;
    restart();
    fill_memory();
    place_jal(32'h0, 32'h100);
    place_jal(32'h100, 32'h140);
    place_jal(32'h140, 32'h100);
    base = ar_count;
    run_for(9);
    if (ar_count - base != 9) begin
      report_error($sformatf("conflict run made %0d requests, expected 9", ar_count - base));
    end
    for (int i = 1; i < 9; i++) begin
      if (stream_pc[i] !== ((i % 2 == 1) ? 32'h100 : 32'h140)) begin
        report_error($sformatf("conflict pc %h at step %0d", stream_pc[i], i));
      end
    end
  endtask

  task automatic test_back_pressure();
    int base;
    restart();
    load_loop_program();
    delays_on = 1'b1;
    base = ar_count;
    run_for(18);
    if (ar_count - base != 9) begin
      report_error($sformatf("delayed run made %0d requests, expected 9", ar_count - base));
    end
    for (int i = 0; i < 18; i++) begin
      if (stream_pc[i] !== ref_pc[i] || stream_data[i] !== ref_data[i]) begin
        report_error($sformatf("delayed stream differs at step %0d", i));
      end
    end
  endtask

  task automatic test_run_gating();
    restart();
    run = 1'b1;
    do begin
      @(posedge clock);
      #1;
    end while (!bus_ar_valid);
    // Refill is under way when run drops
    run = 1'b0;
    repeat (30) begin
      @(posedge clock);
      if (instr_valid) begin
        report_error("instr_valid high while run is low");
      end
    end
    #1;
    if (pending || bus_r_valid || bus_ar_valid) begin
      $display("Refill did not complete while run was low");
      errors++;
    end
    run_for(9);
    if (stream_pc[0] !== `RESET_PC) begin
      report_error($sformatf("resumed at %h, expected reset pc", stream_pc[0]));
    end
  endtask

  // ------------------------------------------------------------
  // Main sequence
  // ------------------------------------------------------------

  initial begin
    run          = 1'b0;
    test_reset   = 1'b0;
    bus_ar_ready = 1'b1;
    bus_r_valid  = 1'b0;
    bus_r_data   = '0;
    delays_on    = 1'b0;
    held_prev    = 1'b0;
    errors       = 0;
    ar_count     = 0;
    delivered    = 0;
    cycles       = 0;
    last_ar_addr = '0;
    load_loop_program();
    reset_model();

    check_reset_state();
    test_cold_misses();
    test_revisit_hits();
    test_conflict();
    test_back_pressure();
    test_run_gating();

    $display("Deliveries %0d, requests %0d, errors %0d", delivered, ar_count, errors);
    if (errors == 0) begin
      $display("No errors");
    end else begin
      $display("Errors found");
    end
    $finish;
  end

endmodule

// File: testbench/fetch_props.sv
module fetch_props (
  input logic                    clock,
  input logic                    reset,
  input logic                    bus_ar_valid,
  input logic                    bus_ar_ready,
  input bus_pkg::addr_t          bus_ar_addr,
  input logic                    fetch_ready,
  input fetch_pkg::refill_state_t state
);

  timeunit 1ns;
  timeprecision 1ps;

  import fetch_pkg::*;

  // ----------------------------------------------------------
  // AR channel
  // ----------------------------------------------------------

  // Pending request keeps valid high and address steady
  ar_held: assert property (@(posedge clock) disable iff (reset)
    (bus_ar_valid && !bus_ar_ready) |=> (bus_ar_valid && $stable(bus_ar_addr)))
    else $error("AR request dropped or its address moved before acceptance");

  // No new request while the filled line is handed out
  no_ar_in_write: assert property (@(posedge clock) disable iff (reset)
    !(bus_ar_valid && state == refill_write))
    else $error("AR valid high in the write state");

  // Instruction port quiet in reset
  quiet_in_reset: assert property (@(posedge clock) reset |-> !fetch_ready)
    else $error("Instruction valid high during reset");

endmodule

bind icache fetch_props u_fetch_props (
  .clock        (clock),
  .reset        (reset),
  .bus_ar_valid (bus_ar_valid),
  .bus_ar_ready (bus_ar_ready),
  .bus_ar_addr  (bus_ar_addr),
  .fetch_ready  (fetch_ready),
  .state        (state)
);

// File: testbench/tb_clock.sv
module tb_clock (
  output logic clock,
  output logic reset
);

  timeunit 1ns;
  timeprecision 1ps;

  // 100 ns period
  initial begin
    clock = 1'b0;
    forever #50 clock = ~clock;
  end

  // Power-on reset held for 10 rising edges
  initial begin
    reset = 1'b1;
    repeat (10) @(posedge clock);
    #1 reset = 1'b0;
  end

endmodule

// File: source/fetch_top.sv
module fetch_top (
  input  logic           clock,
  input  logic           reset,
  input  logic           run,
  input  logic           bus_ar_ready,
  input  logic           bus_r_valid,
  input  bus_pkg::word_t bus_r_data,
  output logic           bus_ar_valid,
  output bus_pkg::addr_t bus_ar_addr,
  output logic           bus_r_ready,
  output logic           instr_valid,
  output bus_pkg::addr_t instr_pc,
  output bus_pkg::word_t instr_data
);

  import bus_pkg::*;

  // Sequencer to cache
  logic  fetch_valid;
  addr_t fetch_pc;

  // Cache to predecoder, sequencer and instruction port
  logic  fetch_ready;
  word_t fetch_data;

  // Predecoder back to sequencer
  logic  redirect;
  addr_t redirect_pc;

  pc_sequencer u_pc_sequencer (
    .clock       (clock),
    .reset       (reset),
    .run         (run),
    .fetch_ready (fetch_ready),
    .redirect    (redirect),
    .redirect_pc (redirect_pc),
    .fetch_valid (fetch_valid),
    .fetch_pc    (fetch_pc)
  );

  icache u_icache (
    .clock        (clock),
    .reset        (reset),
    .fetch_valid  (fetch_valid),
    .fetch_pc     (fetch_pc),
    .fetch_ready  (fetch_ready),
    .fetch_data   (fetch_data),
    .bus_ar_valid (bus_ar_valid),
    .bus_ar_addr  (bus_ar_addr),
    .bus_ar_ready (bus_ar_ready),
    .bus_r_valid  (bus_r_valid),
    .bus_r_data   (bus_r_data),
    .bus_r_ready  (bus_r_ready)
  );

  jal_predecoder u_jal_predecoder (
    .fetch_ready (fetch_ready),
    .fetch_pc    (fetch_pc),
    .fetch_data  (fetch_data),
    .redirect    (redirect),
    .redirect_pc (redirect_pc)
  );

  // Consumer always takes the word, no back-pressure
  assign instr_valid = fetch_ready;
  assign instr_pc    = fetch_pc;
  assign instr_data  = fetch_data;

endmodule

// File: source/jal_predecoder.sv
module jal_predecoder (
  input  logic           fetch_ready,
  input  bus_pkg::addr_t fetch_pc,
  input  bus_pkg::word_t fetch_data,
  output logic           redirect,
  output bus_pkg::addr_t redirect_pc
);

  import bus_pkg::*;

  // JAL major opcode
  localparam logic [6:0] opcode_jal = 7'b110_1111;

  logic  is_jal;
  word_t jal_imm;

  // ----------------------------------------------------------
  // Detect
  // ----------------------------------------------------------

  assign is_jal = (fetch_data[6:0] == opcode_jal);

  // ----------------------------------------------------------
  // J-type immediate
  // ----------------------------------------------------------

  // imm[20|10:1|11|19:12] sits in bits 31:12
  // bit 0 is implicit zero, sign taken from bit 31
  assign jal_imm = {
    {11{fetch_data[31]}},
    fetch_data[31],
    fetch_data[19:12],
    fetch_data[20],
    fetch_data[30:21],
    1'b0
  };

  // PC-relative target
  assign redirect_pc = fetch_pc + jal_imm;

  // Only a delivered word may steer the sequencer
  assign redirect = fetch_ready && is_jal;

endmodule

// File: source/icache.sv
`include "fetch_defines.svh"

module icache (
  input  logic           clock,
  input  logic           reset,
  input  logic           fetch_valid,
  input  bus_pkg::addr_t fetch_pc,
  output logic           fetch_ready,
  output bus_pkg::word_t fetch_data,
  output logic           bus_ar_valid,
  output bus_pkg::addr_t bus_ar_addr,
  input  logic           bus_ar_ready,
  input  logic           bus_r_valid,
  input  bus_pkg::word_t bus_r_data,
  output logic           bus_r_ready
);

  import bus_pkg::*;
  import fetch_pkg::*;

  // Storage, one word per line
  word_t      data_array [0:(1 << `INDEX_WIDTH)-1];
  cache_tag_t tag_array  [0:(1 << `INDEX_WIDTH)-1];
  logic [(1 << `INDEX_WIDTH)-1:0] line_valid;

  // Address split
  cache_index_t index;
  cache_tag_t   tag;

  logic hit;
  logic miss;
  logic ar_fire;
  logic r_fire;

  refill_state_t state;
  refill_state_t state_next;

  // ----------------------------------------------------------
  // Lookup (decode)
  // ----------------------------------------------------------

  // Byte offset bits are dropped, one word per line
  assign index = fetch_pc[`INDEX_WIDTH+`OFFSET_WIDTH-1:`OFFSET_WIDTH];
  assign tag   = fetch_pc[31:`INDEX_WIDTH+`OFFSET_WIDTH];

  // Valid bit and tag must both match
  assign hit  = fetch_valid && line_valid[index] && (tag_array[index] == tag);
  assign miss = fetch_valid && !hit;

  assign fetch_data = data_array[index];

  // Hit answers combinationally
  // In write the line was filled on the R beat, so it hits there too
  assign fetch_ready = hit;

  // ----------------------------------------------------------
  // Refill FSM (execute)
  // ----------------------------------------------------------

  assign ar_fire = bus_ar_valid && bus_ar_ready;
  assign r_fire  = bus_r_valid && bus_r_ready;

  always_ff @(posedge clock) begin
    if (reset) begin
      state <= refill_idle;
    end else begin
      state <= state_next;
    end
  end

  always_comb begin
    state_next = state;
    case (state)
      refill_idle: begin
        if (miss) begin
          state_next = refill_request;
        end
      end
      // Held here until the R beat arrives
      refill_request: begin
        if (r_fire) begin
          state_next = refill_write;
        end
      end
      // One cycle to deliver the new word
      refill_write: begin
        state_next = refill_idle;
      end
      default: begin
        state_next = refill_idle;
      end
    endcase
  end

  // ----------------------------------------------------------
  // AR channel
  // ----------------------------------------------------------

  // Fetch address is stable until the fetch completes
  assign bus_ar_addr = fetch_pc;

  // Raised the cycle after a miss, held until accepted
  always_ff @(posedge clock) begin
    if (reset) begin
      bus_ar_valid <= 1'b0;
    end else if (ar_fire) begin
      bus_ar_valid <= 1'b0;
    end else if (state == refill_idle && miss) begin
      bus_ar_valid <= 1'b1;
    end
  end

  // ----------------------------------------------------------
  // R channel and line fill
  // ----------------------------------------------------------

  // Ready out of reset, dropped after the beat, back up once AR is taken
  always_ff @(posedge clock) begin
    if (reset) begin
      bus_r_ready <= 1'b1;
    end else if (r_fire) begin
      bus_r_ready <= 1'b0;
    end else if (ar_fire) begin
      bus_r_ready <= 1'b1;
    end
  end

  // Every line starts out invalid
  always_ff @(posedge clock) begin
    if (reset) begin
      line_valid <= '0;
    end else if (r_fire) begin
      line_valid[index] <= 1'b1;
    end
  end

  always_ff @(posedge clock) begin
    if (r_fire) begin
      data_array[index] <= bus_r_data;
      tag_array[index]  <= tag;
    end
  end

endmodule

// File: source/pc_sequencer.sv
`include "fetch_defines.svh"

module pc_sequencer (
  input  logic           clock,
  input  logic           reset,
  input  logic           run,
  input  logic           fetch_ready,
  input  logic           redirect,
  input  bus_pkg::addr_t redirect_pc,
  output logic           fetch_valid,
  output bus_pkg::addr_t fetch_pc
);

  import bus_pkg::*;

  // Sequential successor and the chosen next address
  addr_t pc_step;
  addr_t pc_next;
  logic  fetch_fire;

  // ----------------------------------------------------------
  // Request side
  // ----------------------------------------------------------

  // Fetch whenever enabled, no other throttling
  assign fetch_valid = run;

  // Fetch completes when the cache answers the request
  assign fetch_fire = fetch_valid && fetch_ready;

  // ----------------------------------------------------------
  // Next address
  // ----------------------------------------------------------

  // Words are 4 bytes, lines hold one word
  assign pc_step = fetch_pc + addr_t'(4);

  // JAL target takes priority over fall-through
  always_comb begin
    if (redirect) begin
      pc_next = redirect_pc;
    end else begin
      pc_next = pc_step;
    end
  end

  // Address only moves on an accepted fetch
  // so it stays put across a miss or while run is low
  always_ff @(posedge clock) begin
    if (reset) begin
      fetch_pc <= addr_t'(`RESET_PC);
    end else if (fetch_fire) begin
      fetch_pc <= pc_next;
    end
  end

endmodule

// File: source/fetch_pkg.sv
`include "fetch_defines.svh"

package fetch_pkg;

  // ----------------------------------------------------------
  // Cache line addressing
  // ----------------------------------------------------------

  // Selects one line of the direct-mapped arrays
  typedef logic [`INDEX_WIDTH-1:0] cache_index_t;

  // Upper address bits kept next to each line
  // Width is what remains after index and byte offset
  typedef logic [31-`INDEX_WIDTH-`OFFSET_WIDTH:0] cache_tag_t;

  // ----------------------------------------------------------
  // Refill FSM
  // ----------------------------------------------------------

  // idle     waits for a miss
  // request  AR issued, waiting for R data
  // write    line just filled, word handed out
  typedef enum logic [1:0] {
    refill_idle,
    refill_request,
    refill_write
  } refill_state_t;

endpackage

// File: source/bus_pkg.sv
package bus_pkg;

  // ----------------------------------------------------------
  // Read bus types
  // ----------------------------------------------------------

  // Byte address on the AR channel and in the fetch path
  typedef logic [31:0] addr_t;

  // One instruction, or one beat of R channel data
  typedef logic [31:0] word_t;

  // Single-beat bus only
  // No ID, length, size or burst fields travel here

endpackage

// File: source/fetch_defines.svh
`ifndef FETCH_DEFINES_SVH
`define FETCH_DEFINES_SVH

// Cache geometry
// Index bits select one of 2**INDEX_WIDTH lines
`define INDEX_WIDTH 4
// One word per line, so the byte offset is always two bits
`define OFFSET_WIDTH 2

// First fetch address after reset
`define RESET_PC 32'h0000_0000

`endif
